//--- verif/matcalc_input.txt
# name op slot_a slot_b scalar A B err result, op 0 add 1 scalar 2 transpose 3 matmul 4 conv
# matrix is rows cols then cells row by row, rows 0 skips the load, conv and errors omit result
add_2x3       0 0 1 0   2 3 1 2 3 4 5 6   2 3 10 -20 30 100 -100 -50   0   2 3 11 -18 33 104 -95 -44
add_sat_2x2   0 0 1 0   2 2 100 -100 1 2   2 2 50 -60 3 -4   0   2 2 127 -128 4 -2
scal_3x2      1 0 1 4   3 2 1 -2 30 -40 5 0   0 0   0   3 2 4 -8 120 -128 20 0
scal_neg_1x4  1 2 1 -3  1 4 50 -50 7 0   0 0   0   1 4 -128 127 -21 0
trans_2x4     2 0 1 0   2 4 1 2 3 4 5 6 7 8   0 0   0   4 2 1 5 2 6 3 7 4 8
trans_3x1     2 1 0 0   3 1 -7 9 127   0 0   0   1 3 -7 9 127
mm_inner1     3 0 1 0   2 1 3 -2   1 3 4 5 -6   0   2 3 12 15 -18 -8 -10 12
mm_inner2     3 0 1 0   2 2 1 2 3 4   2 2 5 6 7 8   0   2 2 19 22 43 50
mm_inner3     3 0 1 0   1 3 1 2 3   3 1 4 5 6   0   1 1 32
mm_inner4     3 0 1 0   2 4 10 10 10 10 1 -1 1 -1   4 2 5 -5 5 -5 5 -5 5 1   0   2 2 127 -128 0 -6
err_add_shape 0 0 1 0   2 2 1 1 1 1   2 3 1 1 1 1 1 1   1
err_mm_inner  3 0 1 0   2 3 1 2 3 4 5 6   2 2 1 2 3 4   1
err_empty_a   0 3 1 0   0 0   2 2 1 2 3 4   1
conv_sobel    4 0 1 0   0 0   3 3 1 0 -1 2 0 -2 1 0 -1   0
conv_sat      4 0 2 0   0 0   3 3 4 4 4 4 4 4 4 4 4   0
conv_bad_2x2  4 0 1 0   0 0   2 2 1 1 1 1   1
add_reload    0 0 1 0   1 1 5   1 1 -6   0   1 1 -1

//--- list.f
+incdir+include
hw/matcalc_pkg.sv
hw/matrix_store.sv
hw/conv_window.sv
hw/matrix_alu.sv
hw/matcalc_top.sv
verif/matcalc_properties.sv
verif/matcalc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module matcalc_tb -f list.f \
  -o matcalc_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/matcalc_sim 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "=== PASS ===" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- verif/matcalc_tb.sv
// Testbench for the matrix calculator with file driven records and a convolution stream model
`timescale 1ns/1ns

module matcalc_tb;
  import matcalc_pkg::*;

  `include "conv_image.svh"

  localparam int NUM_SLOTS = 4;
  localparam int MAX_TESTS = 32;
  localparam int CONV_LEN  = CONV_ROWS * CONV_COLS;

  logic        clk;
  logic        rst_n;
  logic        load_i;
  logic [1:0]  load_slot_i;
  matrix_t     load_matrix_i;
  logic        start_i;
  op_code_t    op_i;
  logic [1:0]  slot_a_i;
  logic [1:0]  slot_b_i;
  elem_t       scalar_i;
  logic        done_o;
  logic        error_o;
  matrix_t     result_o;
  logic [31:0] cycle_cnt_o;
  logic        stream_valid_o;
  elem_t       stream_data_o;
  logic        stream_last_col_o;
  logic        stream_ready_i;

  // Test records from the input file
  string      t_name   [MAX_TESTS];
  op_code_t   t_op     [MAX_TESTS];
  logic [1:0] t_sa     [MAX_TESTS];
  logic [1:0] t_sb     [MAX_TESTS];
  elem_t      t_scalar [MAX_TESTS];
  matrix_t    t_a      [MAX_TESTS];
  matrix_t    t_b      [MAX_TESTS];
  logic       t_err    [MAX_TESTS];
  matrix_t    t_res    [MAX_TESTS];

  int          num_tests   = 0;
  int          num_conv    = 0;
  int          cycle       = 0;
  int          cycle_limit = 0;
  int          test_errs   = 0;
  int          pass_tests  = 0;
  int          fail_tests  = 0;
  string       cur_name;
  logic [31:0] lcg_state   = 32'd39;

  matcalc_top #(
    .NUM_SLOTS(NUM_SLOTS)
  ) DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .load_i           (load_i),
    .load_slot_i      (load_slot_i),
    .load_matrix_i    (load_matrix_i),
    .start_i          (start_i),
    .op_i             (op_i),
    .slot_a_i         (slot_a_i),
    .slot_b_i         (slot_b_i),
    .scalar_i         (scalar_i),
    .done_o           (done_o),
    .error_o          (error_o),
    .result_o         (result_o),
    .cycle_cnt_o      (cycle_cnt_o),
    .stream_valid_o   (stream_valid_o),
    .stream_data_o    (stream_data_o),
    .stream_last_col_o(stream_last_col_o),
    .stream_ready_i   (stream_ready_i)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Watchdog with a limit that is set once the records are known
  always @(posedge clk) begin
    cycle = cycle + 1;
    if ((cycle_limit > 0) && (cycle >= cycle_limit)) begin
      $display("Run stopped after %0d cycles before all tests finished", cycle);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------
  // Model and file helpers
  // ------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic elem_t clamp_elem(input int value);
    if (value > 127) return 8'sd127;
    if (value < -128) return -8'sd128;
    return elem_t'(value);
  endfunction

  function automatic elem_t conv_expect(input int row, input int col, input matrix_t kernel);
    int    sum;
    elem_t coeff;
    sum = 0;
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        coeff = kernel.cells[r][c];
        sum   = sum + int'(CONV_IMAGE[row + r][col + c]) * int'(coeff);
      end
    end
    return clamp_elem(sum);
  endfunction

  function automatic int exec_cycles(input op_code_t op, input matrix_t a, input matrix_t b);
    if (op == OP_MAT_MUL) return int'(a.rows) * int'(b.cols) * int'(a.cols);
    return int'(a.rows) * int'(a.cols);
  endfunction

  function automatic int next_int(input int fd);
    int value;
    int code;
    value = 0;
    code  = $fscanf(fd, "%d", value);
    return value;
  endfunction

  // Shape first, then the cells row by row
  function automatic matrix_t scan_matrix(input int fd);
    matrix_t m;
    int      rows;
    int      cols;
    m      = '0;
    rows   = next_int(fd);
    cols   = next_int(fd);
    m.rows = dim_t'(rows);
    m.cols = dim_t'(cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        m.cells[r][c] = elem_t'(next_int(fd));
      end
    end
    return m;
  endfunction

  task automatic parse_records();
    int    fd;
    int    code;
    string tok;
    string rest;
    fd = $fopen("verif/matcalc_input.txt", "r");
    if (fd == 0) return;
    while (num_tests < MAX_TESTS) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok[0] == "#") begin
        code = $fgets(rest, fd);
        continue;
      end
      t_name[num_tests]   = tok;
      t_op[num_tests]     = op_code_t'(3'(next_int(fd)));
      t_sa[num_tests]     = 2'(next_int(fd));
      t_sb[num_tests]     = 2'(next_int(fd));
      t_scalar[num_tests] = elem_t'(next_int(fd));
      t_a[num_tests]      = scan_matrix(fd);
      t_b[num_tests]      = scan_matrix(fd);
      t_err[num_tests]    = (next_int(fd) != 0);
      t_res[num_tests]    = '0;
      // Error and convolution records carry no result matrix
      if (!t_err[num_tests] && (t_op[num_tests] != OP_CONV)) begin
        t_res[num_tests] = scan_matrix(fd);
      end
      if (t_op[num_tests] == OP_CONV) num_conv++;
      num_tests++;
    end
    $fclose(fd);
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic verify_matrix(input string what, input matrix_t expected, input matrix_t actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %h actual %h", cur_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic compare_elem(input string what, input elem_t expected, input elem_t actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic expect_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0d actual %0d", cur_name, what, expected, actual);
      test_errs++;
    end
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("%s: ok", cur_name);
      pass_tests++;
    end else begin
      $display("%s: %0d mismatches", cur_name, test_errs);
      fail_tests++;
    end
  endtask

  // ------------------------------
  // One record
  // ------------------------------
  task automatic run_test(input int n);
    int          transfers;
    int          stalls;
    int          waits;
    logic        done_seen;
    logic [31:0] exp_cycles;
    matrix_t     exp_res;
    cur_name  = t_name[n];
    test_errs = 0;
    transfers = 0;
    stalls    = 0;
    waits     = 0;
    done_seen = 1'b0;
    @(negedge clk);
    load_i        = (t_a[n].rows != '0);
    load_slot_i   = t_sa[n];
    load_matrix_i = t_a[n];
    @(negedge clk);
    load_i        = (t_b[n].rows != '0);
    load_slot_i   = t_sb[n];
    load_matrix_i = t_b[n];
    @(negedge clk);
    load_i   = 1'b0;
    op_i     = t_op[n];
    slot_a_i = t_sa[n];
    slot_b_i = t_sb[n];
    scalar_i = t_scalar[n];
    start_i  = 1'b1;
    while (!done_seen) begin
      @(negedge clk);
      waits++;
      if (done_o) begin
        done_seen = 1'b1;
      end else begin
        lcg_state      = lcg_next(lcg_state);
        stream_ready_i = (lcg_state[31:30] != 2'b00);
        // Valid and ready both high here means a transfer at the next rising edge
        if (stream_valid_o && stream_ready_i) begin
          if (transfers < CONV_LEN) begin
            compare_elem($sformatf("stream value %0d", transfers),
                         conv_expect(transfers / CONV_COLS, transfers % CONV_COLS, t_b[n]),
                         stream_data_o);
            expect_value($sformatf("last column at transfer %0d", transfers),
                         32'((transfers % CONV_COLS) == CONV_COLS - 1), 32'(stream_last_col_o));
          end
          transfers++;
        end else if (stream_valid_o) begin
          stalls++;
        end
      end
    end
    expect_value("error flag", 32'(t_err[n]), 32'(error_o));
    if (t_err[n]) exp_cycles = 32'd0;
    else if (t_op[n] == OP_CONV) exp_cycles = 32'(CONV_LEN + 1 + stalls);
    else exp_cycles = 32'(exec_cycles(t_op[n], t_a[n], t_b[n]));
    expect_value("cycle count", exp_cycles, cycle_cnt_o);
    // The start cycle adds one to the execution cycles
    expect_value("cycles until done", exp_cycles + 32'd1, 32'(waits));
    expect_value("transfers", ((t_op[n] == OP_CONV) && !t_err[n]) ? 32'(CONV_LEN) : 32'd0,
                 32'(transfers));
    if (!t_err[n]) begin
      exp_res = t_res[n];
      if (t_op[n] == OP_CONV) begin
        exp_res      = '0;
        exp_res.rows = dim_t'(CONV_ROWS);
        exp_res.cols = dim_t'(CONV_COLS);
      end
      verify_matrix("result", exp_res, result_o);
    end
    start_i = 1'b0;
    finish_test();
  endtask

  initial begin
    rst_n          = 1'b0;
    load_i         = 1'b0;
    load_slot_i    = '0;
    load_matrix_i  = '0;
    start_i        = 1'b0;
    op_i           = OP_ADD;
    slot_a_i       = '0;
    slot_b_i       = '0;
    scalar_i       = '0;
    stream_ready_i = 1'b0;
    parse_records();
    if (num_tests == 0) begin
      $display("No test records could be read from verif/matcalc_input.txt");
      fail_tests++;
    end
    // Reset check counts as one test
    cycle_limit = 16 + 200 * (num_tests + 1) + 400 * num_conv;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    cur_name  = "reset_state";
    test_errs = 0;
    expect_value("done after reset", 32'd0, 32'(done_o));
    expect_value("error after reset", 32'd0, 32'(error_o));
    expect_value("stream valid after reset", 32'd0, 32'(stream_valid_o));
    verify_matrix("result after reset", '0, result_o);
    finish_test();
    for (int n = 0; n < num_tests; n++) begin
      run_test(n);
    end
    $display("%0d tests, %0d passed, %0d failed", pass_tests + fail_tests, pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- verif/matcalc_properties.sv
// Concurrent assertions on the ALU stream handshake and done flag, bound to matrix_alu
`timescale 1ns/1ns

module matcalc_properties (
  input logic               clk,
  input logic               rst_n,
  input logic               done_i,
  input logic               error_i,
  input logic               valid_i,
  input logic               ready_i,
  input matcalc_pkg::elem_t data_i,
  input logic               last_col_i
);

  // ------------------------------
  // Stream and done rules
  // ------------------------------

  // A stalled beat stays offered unchanged
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && !ready_i |=> valid_i && $stable(data_i) && $stable(last_col_i))
    else $error("stream beat changed while stalled");

  a_done_not_streaming: assert property (@(posedge clk) disable iff (!rst_n)
    !(done_i && valid_i))
    else $error("done and stream valid high together");

  // Error only ever shows with done
  a_error_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    error_i |-> done_i)
    else $error("error raised without done");

endmodule

bind matrix_alu matcalc_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .done_i    (done_o),
  .error_i   (error_o),
  .valid_i   (stream_valid_o),
  .ready_i   (stream_ready_i),
  .data_i    (stream_data_o),
  .last_col_i(stream_last_col_o)
);

//--- hw/matcalc_top.sv
// Matrix calculator top level joining slot store, ALU and convolution window
`timescale 1ns/1ns

module matcalc_top #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] load_slot_i,
  input  matcalc_pkg::matrix_t         load_matrix_i,
  input  logic                         start_i,
  input  matcalc_pkg::op_code_t        op_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] slot_a_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] slot_b_i,
  input  matcalc_pkg::elem_t           scalar_i,
  output logic                         done_o,
  output logic                         error_o,
  output matcalc_pkg::matrix_t         result_o,
  output logic [31:0]                  cycle_cnt_o,
  output logic                         stream_valid_o,
  output matcalc_pkg::elem_t           stream_data_o,
  output logic                         stream_last_col_o,
  input  logic                         stream_ready_i
);
  import matcalc_pkg::*;

  matrix_t    mat_a;
  matrix_t    mat_b;
  logic       a_present;
  logic       b_present;
  logic [3:0] conv_row;
  logic [3:0] conv_col;
  elem_t      conv_sum;

  matrix_store #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_i       (load_i),
    .load_slot_i  (load_slot_i),
    .load_matrix_i(load_matrix_i),
    .slot_a_i     (slot_a_i),
    .slot_b_i     (slot_b_i),
    .mat_a_o      (mat_a),
    .mat_b_o      (mat_b),
    .a_present_o  (a_present),
    .b_present_o  (b_present)
  );

  matrix_alu u_alu (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start_i),
    .op_i             (op_i),
    .mat_a_i          (mat_a),
    .mat_b_i          (mat_b),
    .a_present_i      (a_present),
    .b_present_i      (b_present),
    .scalar_i         (scalar_i),
    .conv_row_o       (conv_row),
    .conv_col_o       (conv_col),
    .conv_sum_i       (conv_sum),
    .done_o           (done_o),
    .error_o          (error_o),
    .result_o         (result_o),
    .cycle_cnt_o      (cycle_cnt_o),
    .stream_valid_o   (stream_valid_o),
    .stream_data_o    (stream_data_o),
    .stream_last_col_o(stream_last_col_o),
    .stream_ready_i   (stream_ready_i)
  );

  // Kernel is always slot B
  conv_window u_conv (
    .row_i   (conv_row),
    .col_i   (conv_col),
    .kernel_i(mat_b),
    .sum_o   (conv_sum)
  );

endmodule

//--- hw/matrix_alu.sv
// Matrix ALU with operation FSM, shape checks, element loops, dot product and conv stream
`timescale 1ns/1ns

module matrix_alu (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  matcalc_pkg::op_code_t op_i,
  input  matcalc_pkg::matrix_t  mat_a_i,
  input  matcalc_pkg::matrix_t  mat_b_i,
  input  logic                  a_present_i,
  input  logic                  b_present_i,
  input  matcalc_pkg::elem_t    scalar_i,
  output logic [3:0]            conv_row_o,
  output logic [3:0]            conv_col_o,
  input  matcalc_pkg::elem_t    conv_sum_i,
  output logic                  done_o,
  output logic                  error_o,
  output matcalc_pkg::matrix_t  result_o,
  output logic [31:0]           cycle_cnt_o,
  output logic                  stream_valid_o,
  output matcalc_pkg::elem_t    stream_data_o,
  output logic                  stream_last_col_o,
  input  logic                  stream_ready_i
);
  import matcalc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_DONE
  } state_t;

  localparam logic [3:0] CONV_LAST_ROW = 4'(CONV_ROWS - 1);
  localparam logic [3:0] CONV_LAST_COL = 4'(CONV_COLS - 1);

  state_t      state_q;
  op_code_t    op_q;
  idx_t        i_q, j_q, k_q;
  idx_t        last_i_q, last_j_q, last_k_q;
  logic [3:0]  conv_row_q, conv_col_q;
  accum_t      acc_q;
  matrix_t     result_q;
  logic [31:0] cycle_q;
  logic        done_q, error_q, stream_valid_q;

  logic        use_a, use_b, setup_err;
  dim_t        res_rows, res_cols, res_inner;

  logic        last_i, last_j, last_k;
  accum_t      prod, dot;
  elem_t       cell_d;

  function automatic logic shape_ok(input matrix_t m);
    return (m.rows != '0) && (m.cols != '0) &&
           (m.rows <= dim_t'(MAX_DIM)) && (m.cols <= dim_t'(MAX_DIM));
  endfunction

  // ------------------------------
  // Setup decode
  // ------------------------------

  // Only the operands an operation reads must be loaded, conv reads just B
  always_comb begin
    use_a     = (op_i != OP_CONV);
    use_b     = (op_i == OP_ADD) || (op_i == OP_MAT_MUL) || (op_i == OP_CONV);
    setup_err = (use_a && !(a_present_i && shape_ok(mat_a_i))) ||
                (use_b && !(b_present_i && shape_ok(mat_b_i)));
    res_rows  = mat_a_i.rows;
    res_cols  = mat_a_i.cols;
    res_inner = dim_t'(1);
    case (op_i)
      OP_ADD: begin
        if ((mat_a_i.rows != mat_b_i.rows) || (mat_a_i.cols != mat_b_i.cols)) begin
          setup_err = 1'b1;
        end
      end
      OP_SCALAR_MUL: ;
      OP_TRANSPOSE: begin
        res_rows = mat_a_i.cols;
        res_cols = mat_a_i.rows;
      end
      OP_MAT_MUL: begin
        if (mat_a_i.cols != mat_b_i.rows) begin
          setup_err = 1'b1;
        end
        res_cols  = mat_b_i.cols;
        res_inner = mat_a_i.cols;
      end
      OP_CONV: begin
        if ((mat_b_i.rows != dim_t'(3)) || (mat_b_i.cols != dim_t'(3))) begin
          setup_err = 1'b1;
        end
        res_rows = dim_t'(CONV_ROWS);
        res_cols = dim_t'(CONV_COLS);
      end
      default: setup_err = 1'b1;
    endcase
  end

  // ------------------------------
  // Cell datapath
  // ------------------------------
  assign last_i = (i_q == last_i_q);
  assign last_j = (j_q == last_j_q);
  assign last_k = (k_q == last_k_q);

  always_comb begin
    prod = accum_t'(mat_a_i.cells[i_q][k_q]) * accum_t'(mat_b_i.cells[k_q][j_q]);
    dot  = acc_q + prod;
    case (op_q)
      OP_ADD:        cell_d = saturate(accum_t'(mat_a_i.cells[i_q][j_q]) +
                                       accum_t'(mat_b_i.cells[i_q][j_q]));
      OP_SCALAR_MUL: cell_d = saturate(accum_t'(mat_a_i.cells[i_q][j_q]) *
                                       accum_t'(scalar_i));
      OP_TRANSPOSE:  cell_d = mat_a_i.cells[j_q][i_q];
      default:       cell_d = saturate(dot);
    endcase
  end

  // ------------------------------
  // Sequencer
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= ST_IDLE;
      op_q           <= OP_ADD;
      i_q            <= '0;
      j_q            <= '0;
      k_q            <= '0;
      last_i_q       <= '0;
      last_j_q       <= '0;
      last_k_q       <= '0;
      conv_row_q     <= '0;
      conv_col_q     <= '0;
      acc_q          <= '0;
      result_q       <= '0;
      cycle_q        <= '0;
      done_q         <= 1'b0;
      error_q        <= 1'b0;
      stream_valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            op_q       <= op_i;
            i_q        <= '0;
            j_q        <= '0;
            k_q        <= '0;
            conv_row_q <= '0;
            conv_col_q <= '0;
            acc_q      <= '0;
            cycle_q    <= '0;
            result_q   <= '0;
            if (setup_err) begin
              error_q <= 1'b1;
              done_q  <= 1'b1;
              state_q <= ST_DONE;
            end else begin
              result_q.rows <= res_rows;
              result_q.cols <= res_cols;
              last_i_q      <= idx_t'(res_rows - dim_t'(1));
              last_j_q      <= idx_t'(res_cols - dim_t'(1));
              last_k_q      <= idx_t'(res_inner - dim_t'(1));
              state_q       <= ST_EXEC;
            end
          end
        end

        ST_EXEC: begin
          cycle_q <= cycle_q + 32'd1;
          if (op_q == OP_CONV) begin
            // First EXEC cycle raises valid, then positions move only on transfers
            stream_valid_q <= 1'b1;
            if (stream_valid_q && stream_ready_i) begin
              if (conv_col_q == CONV_LAST_COL) begin
                conv_col_q <= '0;
                if (conv_row_q == CONV_LAST_ROW) begin
                  stream_valid_q <= 1'b0;
                  done_q         <= 1'b1;
                  state_q        <= ST_DONE;
                end else begin
                  conv_row_q <= conv_row_q + 4'd1;
                end
              end else begin
                conv_col_q <= conv_col_q + 4'd1;
              end
            end
          end else begin
            // Inner loop has one step for everything except matrix multiplication
            acc_q <= last_k ? '0 : dot;
            if (!last_k) begin
              k_q <= k_q + idx_t'(1);
            end else begin
              result_q.cells[i_q][j_q] <= cell_d;
              k_q                      <= '0;
              if (last_j) begin
                j_q <= '0;
                if (last_i) begin
                  done_q  <= 1'b1;
                  state_q <= ST_DONE;
                end else begin
                  i_q <= i_q + idx_t'(1);
                end
              end else begin
                j_q <= j_q + idx_t'(1);
              end
            end
          end
        end

        ST_DONE: begin
          if (!start_i) begin
            done_q  <= 1'b0;
            error_q <= 1'b0;
            state_q <= ST_IDLE;
          end
        end

        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign done_o            = done_q;
  assign error_o           = error_q;
  assign result_o          = result_q;
  assign cycle_cnt_o       = cycle_q;
  assign conv_row_o        = conv_row_q;
  assign conv_col_o        = conv_col_q;
  assign stream_valid_o    = stream_valid_q;
  assign stream_data_o     = conv_sum_i;
  assign stream_last_col_o = (conv_col_q == CONV_LAST_COL);

endmodule

//--- hw/conv_window.sv
// Combinational 3 by 3 convolution window over the fixed image table
`timescale 1ns/1ns

module conv_window (
  input  logic [3:0]           row_i,
  input  logic [3:0]           col_i,
  input  matcalc_pkg::matrix_t kernel_i,
  output matcalc_pkg::elem_t   sum_o
);
  import matcalc_pkg::*;

  `include "conv_image.svh"

  localparam int KSIZE = 3;

  accum_t acc;
  accum_t pixel_w;
  accum_t coeff_w;

  // ------------------------------
  // Multiply and accumulate
  // ------------------------------

  // Pixels are unsigned and zero-extended, kernel cells are sign-extended
  always_comb begin
    acc     = '0;
    pixel_w = '0;
    coeff_w = '0;
    for (int r = 0; r < KSIZE; r++) begin
      for (int c = 0; c < KSIZE; c++) begin
        pixel_w = accum_t'(CONV_IMAGE[int'(row_i) + r][int'(col_i) + c]);
        coeff_w = accum_t'(kernel_i.cells[r][c]);
        acc     = acc + pixel_w * coeff_w;
      end
    end
  end

  // Output position stays inside the image, 7 + 2 rows and 9 + 2 columns
  assign sum_o = saturate(acc);

endmodule

//--- hw/matrix_store.sv
// Matrix slot register file with occupancy bits and two read ports
`timescale 1ns/1ns

module matrix_store #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         load_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] load_slot_i,
  input  matcalc_pkg::matrix_t         load_matrix_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] slot_a_i,
  input  logic [$clog2(NUM_SLOTS)-1:0] slot_b_i,
  output matcalc_pkg::matrix_t         mat_a_o,
  output matcalc_pkg::matrix_t         mat_b_o,
  output logic                         a_present_o,
  output logic                         b_present_o
);
  import matcalc_pkg::*;

  matrix_t              slots_q [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] occupied_q;
  matrix_t              load_clean;

  // ------------------------------
  // Load path
  // ------------------------------

  // Zero any cell outside the declared shape before it is stored
  always_comb begin
    load_clean = load_matrix_i;
    for (int r = 0; r < MAX_DIM; r++) begin
      for (int c = 0; c < MAX_DIM; c++) begin
        if ((r >= int'(load_matrix_i.rows)) || (c >= int'(load_matrix_i.cols))) begin
          load_clean.cells[r][c] = '0;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < NUM_SLOTS; s++) begin
        slots_q[s] <= '0;
      end
      occupied_q <= '0;
    end else if (load_i) begin
      slots_q[load_slot_i]    <= load_clean;
      occupied_q[load_slot_i] <= 1'b1;
    end
  end

  // ------------------------------
  // Read ports
  // ------------------------------

  // Both operands are visible whole, so any cell can be read in any cycle
  assign mat_a_o     = slots_q[slot_a_i];
  assign mat_b_o     = slots_q[slot_b_i];
  assign a_present_o = occupied_q[slot_a_i];
  assign b_present_o = occupied_q[slot_b_i];

endmodule

//--- hw/matcalc_pkg.sv
// Shared sizes, element and matrix types, operation codes and saturation
package matcalc_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int MAX_DIM   = 4;
  localparam int IMG_ROWS  = 10;
  localparam int IMG_COLS  = 12;
  localparam int CONV_ROWS = 8;
  localparam int CONV_COLS = 10;

  // ------------------------------
  // Scalar types
  // ------------------------------
  typedef logic signed [7:0]  elem_t;
  // Count of rows or columns, zero is an empty shape
  // Four bits so the 8 by 10 convolution shape fits
  typedef logic [3:0]         dim_t;
  typedef logic [1:0]         idx_t;
  typedef logic signed [23:0] accum_t;
  typedef logic [3:0]         pixel_t;

  // Cells outside rows by cols are kept at zero
  typedef struct packed {
    dim_t                                 rows;
    dim_t                                 cols;
    elem_t [MAX_DIM-1:0][MAX_DIM-1:0]     cells;
  } matrix_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SCALAR_MUL,
    OP_TRANSPOSE,
    OP_MAT_MUL,
    OP_CONV
  } op_code_t;

  // Clamp a wide sum into the element range
  function automatic elem_t saturate(input accum_t value);
    if (value > 24'sd127) begin
      return 8'sd127;
    end else if (value < -24'sd128) begin
      return -8'sd128;
    end
    return value[7:0];
  endfunction

endpackage

//--- include/conv_image.svh
// Fixed 10 by 12 table of 4-bit pixels for the convolution image
// Included inside a module body, one copy per including module

localparam matcalc_pkg::pixel_t CONV_IMAGE
  [matcalc_pkg::IMG_ROWS][matcalc_pkg::IMG_COLS] = '{
  '{4'd3, 4'd7, 4'd2, 4'd9, 4'd0, 4'd5, 4'd1, 4'd8, 4'd4, 4'd6, 4'd3, 4'd2},
  '{4'd8, 4'd1, 4'd6, 4'd4, 4'd7, 4'd3, 4'd9, 4'd0, 4'd5, 4'd2, 4'd8, 4'd1},
  '{4'd4, 4'd9, 4'd0, 4'd2, 4'd6, 4'd8, 4'd3, 4'd5, 4'd7, 4'd1, 4'd4, 4'd9},
  '{4'd7, 4'd3, 4'd8, 4'd5, 4'd1, 4'd4, 4'd9, 4'd2, 4'd0, 4'd6, 4'd7, 4'd3},
  '{4'd2, 4'd6, 4'd4, 4'd0, 4'd8, 4'd7, 4'd5, 4'd3, 4'd1, 4'd9, 4'd2, 4'd4},
  // Lower half of the image
  '{4'd9, 4'd0, 4'd7, 4'd3, 4'd5, 4'd2, 4'd8, 4'd6, 4'd4, 4'd1, 4'd9, 4'd0},
  '{4'd5, 4'd8, 4'd1, 4'd6, 4'd4, 4'd9, 4'd2, 4'd7, 4'd3, 4'd0, 4'd5, 4'd8},
  '{4'd1, 4'd4, 4'd9, 4'd2, 4'd7, 4'd0, 4'd6, 4'd8, 4'd5, 4'd3, 4'd1, 4'd4},
  '{4'd6, 4'd2, 4'd5, 4'd8, 4'd3, 4'd1, 4'd7, 4'd4, 4'd9, 4'd0, 4'd6, 4'd2},
  '{4'd0, 4'd7, 4'd3, 4'd9, 4'd5, 4'd6, 4'd4, 4'd1, 4'd8, 4'd2, 4'd0, 4'd7}
};
